// File: fixed_arith.f
hw/fixed_arith_pkg.sv
hw/fixed_add_unit.sv
hw/fixed_mul_unit.sv
hw/axil_fixed_regs.sv
hw/fixed_arith_top.sv
dv/fixed_arith_asserts.sv
dv/fixed_arith_tb.sv

// File: Makefile
SIM  = obj_dir/Vfixed_arith_tb
SRCS = hw/fixed_arith_pkg.sv hw/fixed_add_unit.sv hw/fixed_mul_unit.sv \
       hw/axil_fixed_regs.sv hw/fixed_arith_top.sv \
       dv/fixed_arith_asserts.sv dv/fixed_arith_tb.sv

.PHONY: all run clean

all: run

$(SIM): $(SRCS) fixed_arith.f
	verilator --binary --timing --assert -f fixed_arith.f --top-module fixed_arith_tb -Mdir obj_dir

run: $(SIM)
	./$(SIM) > sim.log 2>&1; cat sim.log
	@if grep -q "TEST FAILED" sim.log || ! grep -q "TEST OK" sim.log; then \
		echo "simulation failed"; exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log

// File: dv/fixed_arith_tb.sv
`default_nettype none
`timescale 1ns/10ps

module fixed_arith_tb
  import fixed_arith_pkg::*;
();

  localparam int ADDR_W     = 5;
  localparam int CLK_PERIOD = 4;
  localparam int NUM_TABLE  = 8;
  localparam int NUM_RAND   = 40;
  localparam int TIMEOUT_NS = (NUM_TABLE + NUM_RAND + 2) * 100 * CLK_PERIOD;

  typedef struct packed {
    fix_t        a;
    fix_t        b;
    logic [31:0] sum_reg; // expected REG_SUM word
    logic [31:0] full;    // expected REG_PROD_FULL word
  } vec_t;

  logic clk, rst_n;
  logic [ADDR_W-1:0] awaddr, araddr;
  logic awvalid, awready, wvalid, wready, bvalid, bready;
  logic arvalid, arready, rvalid, rready;
  logic [31:0] wdata, rdata;
  logic [3:0]  wstrb;
  logic [1:0]  bresp, rresp;
  int          errors;
  logic [31:0] rng;

  vec_t vectors [NUM_TABLE] = '{
    '{16'h0100, 16'h0100, 32'h0000_0200, 32'h0001_0000}, // 1.0 * 1.0
    '{16'hFF00, 16'h0100, 32'h0001_0000, 32'h00FF_0000}, // sum wraps
    '{16'h0001, 16'h0001, 32'h0000_0002, 32'h0000_0001}, // below resolution
    '{16'h1000, 16'h1000, 32'h0000_2000, 32'h0100_0000}, // exactly 256.0
    '{16'h0180, 16'h0200, 32'h0000_0380, 32'h0003_0000},
    '{16'hFFFF, 16'hFFFF, 32'h0001_FFFE, 32'hFFFE_0001}, // every flag set
    '{16'h0080, 16'h0080, 32'h0000_0100, 32'h0000_4000},
    '{16'h0000, 16'h1234, 32'h0000_1234, 32'h0000_0000}
  };

  fixed_arith_top #(.ADDR_W(ADDR_W)) u_dut (.*);

  always #(CLK_PERIOD / 2) clk = ~clk;

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // reference model of the read map
  function automatic logic [31:0] model_sum(input fix_t a, input fix_t b);
    int unsigned total;
    total = 32'(a) + 32'(b);
    return {15'd0, total >= 32'd65536, total[15:0]}; // carry lands in bit 16
  endfunction

  function automatic logic [31:0] model_full(input fix_t a, input fix_t b);
    return 32'(a) * 32'(b);
  endfunction

  function automatic logic [31:0] pack_prod(input logic [31:0] full);
    return {14'd0, |full[7:0], |full[31:24], full[23:8]};
  endfunction

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] got);
    if (got !== exp)
    begin
      errors++;
      $display("MISMATCH %s: expected 0x%08h actual 0x%08h", name, exp, got);
    end
  endtask

  task automatic axil_write(input logic [31:0] off, input logic [31:0] data);
    awaddr  <= off[ADDR_W-1:0];
    awvalid <= 1'b1;
    wdata   <= data;
    wstrb   <= 4'hF;
    wvalid  <= 1'b1;
    bready  <= 1'b1;
    @(posedge clk);
    while (!(awready && wready))
      @(posedge clk);
    awvalid <= 1'b0;
    wvalid  <= 1'b0;
    @(posedge clk);
    while (!bvalid)
      @(posedge clk);
    check_value("bresp", 32'd0, {30'd0, bresp});
    bready <= 1'b0;
  endtask

  // hold keeps rready low for that many cycles once rvalid is up
  task automatic axil_read(input logic [31:0] off, input int hold, output logic [31:0] data);
    logic [31:0] first;
    araddr  <= off[ADDR_W-1:0];
    arvalid <= 1'b1;
    rready  <= 1'b0;
    @(posedge clk);
    while (!arready)
      @(posedge clk);
    arvalid <= 1'b0;
    @(posedge clk);
    while (!rvalid)
      @(posedge clk);
    check_value("rresp", 32'd0, {30'd0, rresp});
    first = rdata;
    if (hold > 0)
    begin
      repeat (hold) @(posedge clk);
      check_value("rdata held", first, rdata);
    end
    rready <= 1'b1;
    @(posedge clk);
    rready <= 1'b0;
    data = first;
  endtask

  task automatic run_pair(input fix_t a, input fix_t b, input logic [31:0] exp_sum,
                          input logic [31:0] exp_full);
    logic [31:0] got;
    axil_write(REG_OP_A, {16'd0, a});
    axil_write(REG_OP_B, {16'd0, b});
    axil_read(REG_PROD_FULL, 0, got); // issued straight after the B write
    check_value("REG_PROD_FULL", exp_full, got);
    axil_read(REG_PROD, 0, got);
    check_value("REG_PROD", pack_prod(exp_full), got);
    axil_read(REG_SUM, 0, got);
    check_value("REG_SUM", exp_sum, got);
  endtask

  initial
  begin
    #(TIMEOUT_NS);
    $display("timeout: the DUT stopped answering before all tests were done");
    $display("TEST FAILED");
    $finish;
  end

  initial
  begin
    fix_t        a;
    fix_t        b;
    logic [31:0] got;
    clk = 1'b0;
    rst_n = 1'b0;
    awaddr = '0;
    awvalid = 1'b0;
    wdata = '0;
    wstrb = '0;
    wvalid = 1'b0;
    bready = 1'b0;
    araddr = '0;
    arvalid = 1'b0;
    rready = 1'b0;
    errors = 0;
    rng = 32'd54465;
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);

    for (int i = 0; i < NUM_TABLE; i++)
      run_pair(vectors[i].a, vectors[i].b, vectors[i].sum_reg, vectors[i].full);

    for (int i = 0; i < NUM_RAND; i++)
    begin
      rng = xorshift(rng);
      a = rng[15:0];
      rng = xorshift(rng);
      b = rng[15:0];
      run_pair(a, b, model_sum(a, b), model_full(a, b));
    end

    // slow reader, then unmapped offsets
    run_pair(16'h0340, 16'h0210, model_sum(16'h0340, 16'h0210), model_full(16'h0340, 16'h0210));
    axil_read(REG_PROD_FULL, 6, got);
    check_value("REG_PROD_FULL", model_full(16'h0340, 16'h0210), got);
    axil_read(32'h14, 0, got);
    check_value("unmapped 0x14", 32'd0, got);
    axil_read(32'h1C, 3, got);
    check_value("unmapped 0x1C", 32'd0, got);

    $display("errors: %0d", errors);
    if (errors == 0)
      $display("TEST OK");
    else
      $display("TEST FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: dv/fixed_arith_asserts.sv
`default_nettype none
`timescale 1ns/10ps

module fixed_arith_asserts
(
  input logic        clk,
  input logic        rst_n,
  input logic        bvalid,
  input logic        bready,
  input logic        rvalid,
  input logic        rready,
  input logic [31:0] rdata,
  input logic        arready,
  input logic        ops_load
);

  // write response waits for the master
  a_bvalid_held: assert property (@(posedge clk) disable iff (!rst_n)
    bvalid && !bready |=> bvalid)
    else $error("bvalid dropped before bready");

  a_rdata_held: assert property (@(posedge clk) disable iff (!rst_n)
    rvalid && !rready |=> rvalid && $stable(rdata))
    else $error("read response changed before rready");

  // no read while the product of a new load is still in the pipe
  a_ar_hold_off: assert property (@(posedge clk) disable iff (!rst_n)
    $past(ops_load) || $past(ops_load, 2) |-> !arready)
    else $error("arready high with a unit result pending");

endmodule

bind axil_fixed_regs fixed_arith_asserts u_asserts (
  .clk      (clk),
  .rst_n    (rst_n),
  .bvalid   (bvalid),
  .bready   (bready),
  .rvalid   (rvalid),
  .rready   (rready),
  .rdata    (rdata),
  .arready  (arready),
  .ops_load (ops_load)
);

`default_nettype wire

// File: hw/fixed_arith_top.sv
`default_nettype none
`timescale 1ns/10ps

module fixed_arith_top
  import fixed_arith_pkg::*;
#(
  parameter int ADDR_W = 5
)
(
  input  logic              clk,
  input  logic              rst_n,
  input  logic [ADDR_W-1:0] awaddr,
  input  logic              awvalid,
  output logic              awready,
  input  logic [31:0]       wdata,
  input  logic [3:0]        wstrb,
  input  logic              wvalid,
  output logic              wready,
  output logic [1:0]        bresp,
  output logic              bvalid,
  input  logic              bready,
  input  logic [ADDR_W-1:0] araddr,
  input  logic              arvalid,
  output logic              arready,
  output logic [31:0]       rdata,
  output logic [1:0]        rresp,
  output logic              rvalid,
  input  logic              rready
);

  fix_operands_t operands;
  logic          ops_load;
  add_result_t   add_res;
  logic          add_valid;
  mul_result_t   mul_res;
  logic          mul_valid;

  axil_fixed_regs #(
    .ADDR_W (ADDR_W)
  ) u_regs (
    .clk       (clk),
    .rst_n     (rst_n),
    .awaddr    (awaddr),
    .awvalid   (awvalid),
    .awready   (awready),
    .wdata     (wdata),
    .wstrb     (wstrb),
    .wvalid    (wvalid),
    .wready    (wready),
    .bresp     (bresp),
    .bvalid    (bvalid),
    .bready    (bready),
    .araddr    (araddr),
    .arvalid   (arvalid),
    .arready   (arready),
    .rdata     (rdata),
    .rresp     (rresp),
    .rvalid    (rvalid),
    .rready    (rready),
    .operands  (operands),
    .ops_load  (ops_load),
    .add_res   (add_res),
    .add_valid (add_valid),
    .mul_res   (mul_res),
    .mul_valid (mul_valid)
  );

  // both units see the same operands and load strobe
  fixed_add_unit u_add (
    .clk       (clk),
    .rst_n     (rst_n),
    .operands  (operands),
    .ops_load  (ops_load),
    .add_res   (add_res),
    .add_valid (add_valid)
  );

  fixed_mul_unit u_mul (
    .clk       (clk),
    .rst_n     (rst_n),
    .operands  (operands),
    .ops_load  (ops_load),
    .mul_res   (mul_res),
    .mul_valid (mul_valid)
  );

endmodule

`default_nettype wire

// File: hw/axil_fixed_regs.sv
`default_nettype none
`timescale 1ns/10ps

module axil_fixed_regs
  import fixed_arith_pkg::*;
#(
  parameter int ADDR_W = 5
)
(
  input  logic              clk,
  input  logic              rst_n,
  input  logic [ADDR_W-1:0] awaddr,
  input  logic              awvalid,
  output logic              awready,
  input  logic [31:0]       wdata,
  input  logic [3:0]        wstrb,
  input  logic              wvalid,
  output logic              wready,
  output logic [1:0]        bresp,
  output logic              bvalid,
  input  logic              bready,
  input  logic [ADDR_W-1:0] araddr,
  input  logic              arvalid,
  output logic              arready,
  output logic [31:0]       rdata,
  output logic [1:0]        rresp,
  output logic              rvalid,
  input  logic              rready,
  output fix_operands_t     operands,
  output logic              ops_load,
  input  add_result_t       add_res,
  input  logic              add_valid,
  input  mul_result_t       mul_res,
  input  logic              mul_valid
);

  logic [31:0] wr_off;
  logic [31:0] rd_off;
  logic        wr_fire;
  logic        wr_op_a;
  logic        wr_op_b;
  logic        rd_fire;
  logic        add_pend;
  logic        mul_pend;
  logic [31:0] rd_map;

  // only bytes 0 and 1 carry operand data
  function automatic fix_t merge_bytes(fix_t cur, logic [31:0] data, logic [3:0] strb);
    fix_t res;
    res = cur;
    for (int i = 0; i < FIX_W / 8; i++)
    begin
      if (strb[i])
        res[i*8 +: 8] = data[i*8 +: 8];
    end
    return res;
  endfunction

  assign wr_off = 32'(awaddr) & ~32'h3; // word aligned
  assign rd_off = 32'(araddr) & ~32'h3;

  // write channel, one outstanding response
  assign awready = ~bvalid;
  assign wready  = ~bvalid;
  assign wr_fire = awvalid & wvalid & ~bvalid;
  assign wr_op_a = wr_fire & (wr_off == REG_OP_A);
  assign wr_op_b = wr_fire & (wr_off == REG_OP_B);
  assign bresp   = RESP_OKAY;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      bvalid   <= 1'b0;
      ops_load <= 1'b0;
      operands <= '0;
    end
    else
    begin
      if (wr_fire)
        bvalid <= 1'b1;
      else if (bready)
        bvalid <= 1'b0;

      ops_load <= wr_op_a | wr_op_b; // lines up with the new operand value
      if (wr_op_a)
        operands.a <= merge_bytes(operands.a, wdata, wstrb);
      if (wr_op_b)
        operands.b <= merge_bytes(operands.b, wdata, wstrb);
    end
  end

  // results still in flight for the latest operands
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      add_pend <= 1'b0;
      mul_pend <= 1'b0;
    end
    else
    begin
      if (ops_load)
        add_pend <= 1'b1;
      else if (add_valid)
        add_pend <= 1'b0;

      // a new load wins over the valid of an older one
      if (ops_load)
        mul_pend <= 1'b1;
      else if (mul_valid)
        mul_pend <= 1'b0;
    end
  end

  // ops_load covers the cycle before the flags rise
  assign arready = ~rvalid & ~add_pend & ~mul_pend & ~ops_load;
  assign rd_fire = arvalid & arready;
  assign rresp   = RESP_OKAY;

  // combined read map
  always_comb
  begin
    case (rd_off)
      REG_SUM:       rd_map = {15'd0, add_res.overflow, add_res.sum};
      REG_PROD:      rd_map = {14'd0, mul_res.precision_lost, mul_res.overflow, mul_res.product};
      REG_PROD_FULL: rd_map = mul_res.full;
      default:       rd_map = 32'd0; // operand and unmapped offsets
    endcase
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      rvalid <= 1'b0;
    else if (rd_fire)
      rvalid <= 1'b1;
    else if (rready)
      rvalid <= 1'b0;
  end

  always_ff @(posedge clk)
  begin
    if (rd_fire)
      rdata <= rd_map; // held until rready
  end

endmodule

`default_nettype wire

// File: hw/fixed_mul_unit.sv
`default_nettype none
`timescale 1ns/10ps

module fixed_mul_unit
  import fixed_arith_pkg::*;
(
  input  logic          clk,
  input  logic          rst_n,
  input  fix_operands_t operands,
  input  logic          ops_load,
  output mul_result_t   mul_res,
  output logic          mul_valid
);

  logic [PROD_W-1:0] multiplicand;
  logic [PROD_W-1:0] pp      [FIX_W]; // one per multiplier bit
  logic [PROD_W-1:0] group_d [4];
  logic [PROD_W-1:0] group_q [4];
  logic              s1_valid;
  logic [PROD_W-1:0] full_sum;

  assign multiplicand = PROD_W'(operands.a);

  // shift and gate
  always_comb
  begin
    for (int i = 0; i < FIX_W; i++)
    begin
      pp[i] = (multiplicand << i) & {PROD_W{operands.b[i]}};
    end
  end

  // four interleaved groups of four partial products
  always_comb
  begin
    group_d[0] = pp[0] + pp[4] + pp[8]  + pp[15];
    group_d[1] = pp[1] + pp[5] + pp[9]  + pp[14];
    group_d[2] = pp[2] + pp[6] + pp[10] + pp[13];
    group_d[3] = pp[3] + pp[7] + pp[11] + pp[12];
  end

  // stage one, group sums
  always_ff @(posedge clk)
  begin
    if (ops_load)
    begin
      group_q <= group_d;
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      s1_valid <= 1'b0;
    else
      s1_valid <= ops_load;
  end

  assign full_sum = group_q[0] + group_q[1] + group_q[2] + group_q[3];

  // stage two, full product and the 8.8 view of it
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      mul_res   <= '0;
      mul_valid <= 1'b0;
    end
    else
    begin
      mul_valid <= s1_valid;
      if (s1_valid)
      begin
        mul_res.full           <= full_sum;
        mul_res.product        <= full_sum[FIX_W+FRAC_W-1:FRAC_W];
        mul_res.overflow       <= |full_sum[PROD_W-1:FIX_W+FRAC_W]; // integer part past 8 bits
        mul_res.precision_lost <= |full_sum[FRAC_W-1:0];
      end
    end
  end

endmodule

`default_nettype wire

// File: hw/fixed_add_unit.sv
`default_nettype none
`timescale 1ns/10ps

module fixed_add_unit
  import fixed_arith_pkg::*;
(
  input  logic          clk,
  input  logic          rst_n,
  input  fix_operands_t operands,
  input  logic          ops_load,
  output add_result_t   add_res,
  output logic          add_valid
);

  logic [FIX_W:0] sum_ext; // one extra bit for the carry

  assign sum_ext = {1'b0, operands.a} + {1'b0, operands.b};

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      add_res   <= '0;
      add_valid <= 1'b0;
    end
    else
    begin
      add_valid <= ops_load; // one pulse per load
      if (ops_load)
      begin
        add_res.sum      <= sum_ext[FIX_W-1:0];
        add_res.overflow <= sum_ext[FIX_W];
      end
    end
  end

endmodule

`default_nettype wire

// File: hw/fixed_arith_pkg.sv
`default_nettype none

package fixed_arith_pkg;

  // unsigned 8.8 format
  localparam int FIX_W  = 16;
  localparam int FRAC_W = 8;
  localparam int PROD_W = 32; // full product before truncation

  // register map, byte offsets
  localparam logic [31:0] REG_OP_A      = 32'h00;
  localparam logic [31:0] REG_OP_B      = 32'h04;
  localparam logic [31:0] REG_SUM       = 32'h08;
  localparam logic [31:0] REG_PROD      = 32'h0C;
  localparam logic [31:0] REG_PROD_FULL = 32'h10;

  localparam logic [1:0] RESP_OKAY = 2'b00;

  typedef logic [FIX_W-1:0] fix_t;

  typedef struct packed {
    fix_t a; // multiplicand
    fix_t b; // multiplier
  } fix_operands_t;

  typedef struct packed {
    fix_t sum;
    logic overflow; // carry out of the integer part
  } add_result_t;

  typedef struct packed {
    logic [PROD_W-1:0] full;
    fix_t              product; // full[23:8]
    logic              overflow;
    logic              precision_lost;
  } mul_result_t;

endpackage

`default_nettype wire
